// ==== compile.f ====
hdl/blimp_pkg.sv
hdl/fetch_unit.sv
hdl/decode_issue_unit.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/writeback_commit_unit.sv
hdl/blimp_core.sv
test/blimp_tb_asserts.sv
test/blimp_tb.sv

// ==== hdl/alu_unit.sv ====
//--------------------
// One-cycle adder pipe
//--------------------
`timescale 1ns/1ps
`default_nettype none

module alu_unit import blimp_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  d_x_t d,
  output x_w_t w
);

  x_w_t res;

  // Sum of both operands, addi immediate already in op2
  always_comb begin
    res.val   = d.val;
    res.seq   = d.seq;
    res.preg  = d.preg;
    res.wen   = d.wen;
    res.wdata = d.op1 + d.op2;
  end

  // Single result register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w <= '0;
    end else begin
      w <= res;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/blimp_core.sv ====
//--------------------
// Core top level: fetch, decode-issue,
// ALU, multiplier, writeback-commit
//--------------------
`timescale 1ns/1ps
`default_nettype none

module blimp_core import blimp_pkg::*; #(
  parameter int p_seq_num_bits  = 3,
  parameter int p_num_phys_regs = 36,
  parameter int p_mul_stages    = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] inst_mem_addr,
  input  logic [31:0] inst_mem_data,
  // Commit trace
  output logic        trace_val,
  output logic [31:0] trace_pc,
  output logic [4:0]  trace_waddr,
  output logic [31:0] trace_wdata,
  output logic        trace_wen
);

  f_d_t                      f_d;
  logic                      stall;
  logic                      alloc, rob_full;
  logic [xlen-1:0]           alloc_pc;
  arch_addr_t                alloc_waddr;
  preg_t                     alloc_free_preg;
  logic [p_seq_num_bits-1:0] rob_seq;
  d_x_t                      alu_d, mul_d;
  x_w_t                      alu_w, mul_w;
  complete_t                 complete, complete_mul;
  commit_t                   commit;

  //--------------------
  // Units
  //--------------------
  fetch_unit fu (
    .clk, .rst_n, .inst_mem_addr, .inst_mem_data, .stall, .f_d
  );

  decode_issue_unit #(
    .p_seq_num_bits  (p_seq_num_bits),
    .p_num_phys_regs (p_num_phys_regs)
  ) diu (
    .clk, .rst_n, .f_d, .stall,
    .alloc, .alloc_pc, .alloc_waddr, .alloc_free_preg, .rob_seq, .rob_full,
    .alu_d, .mul_d, .complete, .complete_mul, .commit
  );

  alu_unit alu_xu (.clk, .rst_n, .d(alu_d), .w(alu_w));

  mul_unit #(.p_mul_stages(p_mul_stages)) mul_xu (.clk, .rst_n, .d(mul_d), .w(mul_w));

  writeback_commit_unit #(.p_seq_num_bits(p_seq_num_bits)) wcu (
    .clk, .rst_n,
    .alloc, .alloc_pc, .alloc_waddr, .alloc_free_preg, .rob_seq, .rob_full,
    .alu_w, .mul_w, .complete, .complete_mul, .commit
  );

  // Trace is the commit record
  assign trace_val   = commit.val;
  assign trace_pc    = commit.pc;
  assign trace_waddr = commit.waddr;
  assign trace_wdata = commit.wdata;
  assign trace_wen   = commit.wen;

endmodule

`default_nettype wire

// ==== hdl/blimp_pkg.sv ====
//--------------------
// Shared core definitions: opcodes,
// instruction fields, stage payload structs
//--------------------
`default_nettype none

package blimp_pkg;

  // Widths
  localparam int xlen          = 32;
  localparam int max_seq_bits  = 8;
  localparam int max_preg_bits = 8;

  typedef logic [4:0]               arch_addr_t;
  typedef logic [max_seq_bits-1:0]  seq_t;
  typedef logic [max_preg_bits-1:0] preg_t;

  // Decoded operation
  typedef enum logic [1:0] {
    op_add  = 2'd0,
    op_addi = 2'd1,
    op_mul  = 2'd2,
    op_nop  = 2'd3
  } opcode_e;

  //--------------------
  // Instruction fields
  //--------------------
  localparam int inst_opc_lo = 0;
  localparam int inst_rd_lo  = 7;
  localparam int inst_f3_lo  = 12;
  localparam int inst_rs1_lo = 15;
  localparam int inst_rs2_lo = 20;
  localparam int inst_f7_lo  = 25;
  localparam int inst_imm_lo = 20;

  localparam logic [6:0] opc_reg = 7'b0110011;
  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [6:0] f7_add  = 7'b0000000;
  localparam logic [6:0] f7_mul  = 7'b0000001;
  localparam logic [2:0] f3_add  = 3'b000;

  //--------------------
  // Stage payloads
  //--------------------
  typedef struct packed {
    logic            val;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } f_d_t;

  typedef struct packed {
    logic            val;
    seq_t            seq;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    opcode_e         op;
    preg_t           preg;
    logic            wen;
  } d_x_t;

  typedef struct packed {
    logic            val;
    seq_t            seq;
    preg_t           preg;
    logic            wen;
    logic [xlen-1:0] wdata;
  } x_w_t;

  // Result broadcast back to the register file
  typedef struct packed {
    logic            val;
    preg_t           preg;
    logic [xlen-1:0] wdata;
    logic            wen;
  } complete_t;

  typedef struct packed {
    logic            val;
    seq_t            seq;
    logic [xlen-1:0] pc;
    arch_addr_t      waddr;
    logic [xlen-1:0] wdata;
    logic            wen;
    preg_t           free_preg;
  } commit_t;

endpackage

`default_nettype wire

// ==== hdl/decode_issue_unit.sv ====
//--------------------
// Decode and issue: rename map, free list,
// physical register file, ready bits, steering
//--------------------
`timescale 1ns/1ps
`default_nettype none

module decode_issue_unit import blimp_pkg::*; #(
  parameter int p_seq_num_bits  = 3,
  parameter int p_num_phys_regs = 36
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  f_d_t                      f_d,
  output logic                      stall,
  // ROB allocation
  output logic                      alloc,
  output logic [xlen-1:0]           alloc_pc,
  output arch_addr_t                alloc_waddr,
  output preg_t                     alloc_free_preg,
  input  logic [p_seq_num_bits-1:0] rob_seq,
  input  logic                      rob_full,
  // Execute pipes
  output d_x_t                      alu_d,
  output d_x_t                      mul_d,
  // From writeback
  input  complete_t                 complete,
  input  complete_t                 complete_mul,
  input  commit_t                   commit
);

  localparam int p_preg_bits = $clog2(p_num_phys_regs);
  // Registers above x31 start out free
  localparam int fl_depth    = p_num_phys_regs - 32;
  localparam int fl_ptr_bits = (fl_depth > 1) ? $clog2(fl_depth) : 1;
  localparam int fl_cnt_bits = $clog2(fl_depth + 1);

  logic [p_preg_bits-1:0]     map_q [32];
  logic [xlen-1:0]            prf_q [p_num_phys_regs];
  logic [p_num_phys_regs-1:0] ready_q;
  logic [p_preg_bits-1:0]     fl_q [fl_depth];
  logic [fl_ptr_bits-1:0]     fl_head_q, fl_tail_q;
  logic [fl_cnt_bits-1:0]     fl_cnt_q;

  logic [6:0]             opcode, funct7;
  logic [2:0]             funct3;
  arch_addr_t             rd, rs1, rs2;
  logic [xlen-1:0]        imm;
  opcode_e                op;
  logic                   use_rs1, use_rs2, has_dest;
  logic [p_preg_bits-1:0] src1_p, src2_p, old_p, new_p;
  logic                   fl_push, fl_pop, issue;
  d_x_t                   iss_q;
  logic                   iss_mul_q;

  function automatic logic [fl_ptr_bits-1:0] fl_next(input logic [fl_ptr_bits-1:0] p);
    fl_next = (p == fl_ptr_bits'(fl_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  //--------------------
  // Decode
  //--------------------
  assign opcode = f_d.inst[inst_opc_lo +: 7];
  assign rd     = f_d.inst[inst_rd_lo +: 5];
  assign funct3 = f_d.inst[inst_f3_lo +: 3];
  assign rs1    = f_d.inst[inst_rs1_lo +: 5];
  assign rs2    = f_d.inst[inst_rs2_lo +: 5];
  assign funct7 = f_d.inst[inst_f7_lo +: 7];
  // I-type immediate, sign extended
  assign imm    = {{(xlen-12){f_d.inst[31]}}, f_d.inst[inst_imm_lo +: 12]};

  always_comb begin
    op = op_nop;
    if (opcode == opc_reg && funct3 == f3_add) begin
      if (funct7 == f7_mul) op = op_mul;
      else if (funct7 == f7_add) op = op_add;
    end else if (opcode == opc_imm && funct3 == f3_add) begin
      op = op_addi;
    end
  end

  assign use_rs1  = (op != op_nop);
  assign use_rs2  = (op == op_add) || (op == op_mul);
  // x0 destination takes no register
  assign has_dest = use_rs1 && (rd != 5'd0);

  //--------------------
  // Rename and stall
  //--------------------
  assign src1_p = map_q[rs1];
  assign src2_p = map_q[rs2];
  assign old_p  = map_q[rd];
  assign new_p  = fl_q[fl_head_q];

  // No bypass from complete, ready bit is seen next cycle
  assign stall = f_d.val && ((use_rs1 && !ready_q[src1_p]) ||
                             (use_rs2 && !ready_q[src2_p]) ||
                             rob_full ||
                             (has_dest && fl_cnt_q == '0));
  assign issue = f_d.val && !stall;

  assign alloc           = issue;
  assign alloc_pc        = f_d.pc;
  assign alloc_waddr     = rd;
  assign alloc_free_preg = preg_t'(old_p);

  // Commit hands back the displaced mapping
  assign fl_push = commit.val && commit.wen;
  assign fl_pop  = issue && has_dest;

  //--------------------
  // State update
  //--------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity map, x0 lives in preg 0
      for (int i = 0; i < 32; i++) map_q[i] <= p_preg_bits'(i);
      for (int i = 0; i < p_num_phys_regs; i++) prf_q[i] <= '0;
      for (int i = 0; i < fl_depth; i++) fl_q[i] <= p_preg_bits'(32 + i);
      ready_q   <= '1;
      fl_head_q <= '0;
      fl_tail_q <= '0;
      fl_cnt_q  <= fl_cnt_bits'(fl_depth);
      iss_q     <= '0;
      iss_mul_q <= 1'b0;
    end else begin
      // Two write ports, ALU and multiplier
      if (complete.val && complete.wen && complete.preg != '0) begin
        prf_q[complete.preg[p_preg_bits-1:0]]   <= complete.wdata;
        ready_q[complete.preg[p_preg_bits-1:0]] <= 1'b1;
      end
      if (complete_mul.val && complete_mul.wen && complete_mul.preg != '0) begin
        prf_q[complete_mul.preg[p_preg_bits-1:0]]   <= complete_mul.wdata;
        ready_q[complete_mul.preg[p_preg_bits-1:0]] <= 1'b1;
      end
      if (fl_push) begin
        fl_q[fl_tail_q] <= commit.free_preg[p_preg_bits-1:0];
        fl_tail_q       <= fl_next(fl_tail_q);
      end
      if (fl_pop) begin
        map_q[rd]      <= new_p;
        ready_q[new_p] <= 1'b0;
        fl_head_q      <= fl_next(fl_head_q);
      end
      fl_cnt_q <= fl_cnt_q + fl_cnt_bits'(fl_push) - fl_cnt_bits'(fl_pop);

      // Issue register, shared by both pipes
      iss_q.val <= issue;
      if (issue) begin
        iss_q.seq  <= seq_t'(rob_seq);
        iss_q.op1  <= use_rs1 ? prf_q[src1_p] : '0;
        iss_q.op2  <= (op == op_addi) ? imm : (use_rs2 ? prf_q[src2_p] : '0);
        iss_q.op   <= op;
        iss_q.preg <= has_dest ? preg_t'(new_p) : '0;
        iss_q.wen  <= has_dest;
        iss_mul_q  <= (op == op_mul);
      end
    end
  end

  // Steer to one pipe
  always_comb begin
    alu_d     = iss_q;
    alu_d.val = iss_q.val && !iss_mul_q;
    mul_d     = iss_q;
    mul_d.val = iss_q.val && iss_mul_q;
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
//--------------------
// Fetch unit: program counter,
// instruction request, F/D register
//--------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import blimp_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Instruction memory read port
  output logic [31:0] inst_mem_addr,
  input  logic [31:0] inst_mem_data,

  // Decode side
  input  logic        stall,
  output f_d_t        f_d
);

  logic [xlen-1:0] pc_q;

  // Combinational read, address is simply the PC
  assign inst_mem_addr = pc_q;

  //--------------------
  // PC and F/D register
  //--------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
      f_d  <= '0;
    end else if (!stall) begin
      // Word at pc_q lands in F/D, PC moves on
      f_d.val  <= 1'b1;
      f_d.pc   <= pc_q;
      f_d.inst <= inst_mem_data;
      pc_q     <= pc_q + 32'd4;
    end
    // Stalled: hold F/D and the request address
  end

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
//--------------------
// Pipelined multiplier,
// low word of the product
//--------------------
`timescale 1ns/1ps
`default_nettype none

module mul_unit import blimp_pkg::*; #(
  parameter int p_mul_stages = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  d_x_t d,
  output x_w_t w
);

  x_w_t pipe_q [p_mul_stages];
  x_w_t res;

  //--------------------
  // Product into stage 0
  //--------------------
  always_comb begin
    res.val  = d.val;
    res.seq  = d.seq;
    res.preg = d.preg;
    res.wen  = d.wen;
    // Truncated to xlen, low half only
    res.wdata = d.op1 * d.op2;
  end

  //--------------------
  // Shift chain
  //--------------------
  // Each stage has its own valid and tags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < p_mul_stages; i++) pipe_q[i] <= '0;
    end else begin
      pipe_q[0] <= res;
      for (int i = 1; i < p_mul_stages; i++) pipe_q[i] <= pipe_q[i-1];
    end
  end

  // Last stage goes to writeback
  assign w = pipe_q[p_mul_stages-1];

endmodule

`default_nettype wire

// ==== hdl/writeback_commit_unit.sv ====
//--------------------
// Writeback and commit: reorder buffer,
// completion, in-order retire
//--------------------
`timescale 1ns/1ps
`default_nettype none

module writeback_commit_unit import blimp_pkg::*; #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // Allocation from decode
  input  logic                      alloc,
  input  logic [xlen-1:0]           alloc_pc,
  input  arch_addr_t                alloc_waddr,
  input  preg_t                     alloc_free_preg,
  output logic [p_seq_num_bits-1:0] rob_seq,
  output logic                      rob_full,
  // Execute results
  input  x_w_t                      alu_w,
  input  x_w_t                      mul_w,
  // Broadcast and retire
  output complete_t                 complete,
  output complete_t                 complete_mul,
  output commit_t                   commit
);

  localparam int rob_depth = 1 << p_seq_num_bits;

  // Pointers carry a wrap bit for full/empty
  logic [p_seq_num_bits:0]   head_q, tail_q;
  logic [p_seq_num_bits-1:0] head_idx, tail_idx, alu_idx, mul_idx;
  logic [rob_depth-1:0]      busy_q, done_q;
  logic                      do_commit;

  // Entry payload
  logic [xlen-1:0] pc_q    [rob_depth];
  arch_addr_t      waddr_q [rob_depth];
  preg_t           free_q  [rob_depth];
  logic [xlen-1:0] wdata_q [rob_depth];
  logic [rob_depth-1:0] wen_q;

  assign head_idx = head_q[p_seq_num_bits-1:0];
  assign tail_idx = tail_q[p_seq_num_bits-1:0];
  assign alu_idx  = alu_w.seq[p_seq_num_bits-1:0];
  assign mul_idx  = mul_w.seq[p_seq_num_bits-1:0];

  assign rob_seq  = tail_idx;
  assign rob_full = (head_q[p_seq_num_bits] != tail_q[p_seq_num_bits]) &&
                    (head_idx == tail_idx);

  //--------------------
  // Completion broadcast
  //--------------------
  // Same cycle as the pipe result
  always_comb begin
    complete.val       = alu_w.val;
    complete.preg      = alu_w.preg;
    complete.wdata     = alu_w.wdata;
    complete.wen       = alu_w.wen;
    complete_mul.val   = mul_w.val;
    complete_mul.preg  = mul_w.preg;
    complete_mul.wdata = mul_w.wdata;
    complete_mul.wen   = mul_w.wen;
  end

  //--------------------
  // Commit
  //--------------------
  // Head retires once done, one per cycle
  assign do_commit = busy_q[head_idx] && done_q[head_idx];

  always_comb begin
    commit.val       = do_commit;
    commit.seq       = seq_t'(head_idx);
    commit.pc        = pc_q[head_idx];
    commit.waddr     = waddr_q[head_idx];
    commit.wdata     = wdata_q[head_idx];
    commit.wen       = wen_q[head_idx];
    commit.free_preg = free_q[head_idx];
  end

  // Control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      busy_q <= '0;
      done_q <= '0;
    end else begin
      // Out of order marking
      if (alu_w.val) done_q[alu_idx] <= 1'b1;
      if (mul_w.val) done_q[mul_idx] <= 1'b1;
      if (alloc) begin
        busy_q[tail_idx] <= 1'b1;
        done_q[tail_idx] <= 1'b0;
        tail_q           <= tail_q + 1'b1;
      end
      if (do_commit) begin
        busy_q[head_idx] <= 1'b0;
        head_q           <= head_q + 1'b1;
      end
    end
  end

  // Entry contents
  always_ff @(posedge clk) begin
    if (alloc) begin
      pc_q[tail_idx]    <= alloc_pc;
      waddr_q[tail_idx] <= alloc_waddr;
      free_q[tail_idx]  <= alloc_free_preg;
    end
    if (alu_w.val) begin
      wdata_q[alu_idx] <= alu_w.wdata;
      wen_q[alu_idx]   <= alu_w.wen;
    end
    if (mul_w.val) begin
      wdata_q[mul_idx] <= mul_w.wdata;
      wen_q[mul_idx]   <= mul_w.wen;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module blimp_tb -f compile.f -o blimp_sim &&
./obj_dir/blimp_sim | tee /dev/stderr | grep "RESULT: PASS" > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== test/blimp_tb.sv ====
//--------------------
// Core testbench: clock, reset, programs,
// ISA reference model, commit checker, watchdog
//--------------------
`timescale 1ns/1ps
`default_nettype none

module blimp_tb;

  localparam int clk_period    = 100;
  localparam int mem_words     = 256;
  localparam int num_phys_regs = 36;
  localparam int recycle_len   = 120;
  localparam int rand_len      = 64;
  // Instruction count over all tests, sets the watchdog
  localparam int total_insts   = 3 + 8 + 10 + recycle_len + 7 + rand_len;
  // addi x0, x0, 0
  localparam logic [31:0] nop_inst = 32'h00000013;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } commit_exp_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] inst_mem_addr;
  logic [31:0] inst_mem_data;
  logic        trace_val;
  logic [31:0] trace_pc;
  logic [4:0]  trace_waddr;
  logic [31:0] trace_wdata;
  logic        trace_wen;

  logic [31:0] imem [mem_words];
  logic [31:0] lfsr_state;
  commit_exp_t exp_c;
  logic        checking;
  int          commit_cnt;
  int          test_num;
  int          n_checks;
  int          n_errors;
  int          n_passed;
  int          n_failed;

  blimp_core #(
    .p_seq_num_bits  (3),
    .p_num_phys_regs (num_phys_regs),
    .p_mul_stages    (4)
  ) dut0 (
    .clk, .rst_n, .inst_mem_addr, .inst_mem_data,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

  bind blimp_core blimp_tb_asserts asserts0 (
    .clk(clk), .rst_n(rst_n), .inst_mem_addr(inst_mem_addr),
    .trace_val(trace_val), .trace_pc(trace_pc)
  );

  // Combinational instruction port
  assign inst_mem_data = imem[inst_mem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //--------------------
  // Encoders and LFSR
  //--------------------
  function automatic logic [31:0] enc_rtype(input logic [6:0] f7, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return enc_rtype(7'h00, rd, rs1, rs2);
  endfunction

  function automatic logic [31:0] enc_mul(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return enc_rtype(7'h01, rd, rs1, rs2);
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = 32'h0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  //--------------------
  // Reference model
  //--------------------
  // In-order ISA run up to commit n
  function automatic commit_exp_t ref_commit(input int n);
    logic [31:0] regs [32];
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic        known;
    commit_exp_t e;
    e = '0;
    for (int r = 0; r < 32; r++) regs[r] = 32'h0;
    for (int i = 0; i <= n; i++) begin
      inst  = imem[i % mem_words];
      a     = regs[inst[19:15]];
      b     = regs[inst[24:20]];
      imm   = {{20{inst[31]}}, inst[31:20]};
      res   = 32'h0;
      known = 1'b1;
      if (inst[14:12] != 3'b000) known = 1'b0;
      else if (inst[6:0] == 7'b0010011) res = a + imm;
      else if (inst[6:0] == 7'b0110011 && inst[31:25] == 7'h00) res = a + b;
      else if (inst[6:0] == 7'b0110011 && inst[31:25] == 7'h01) res = a * b;
      else known = 1'b0;
      e.pc    = 32'(i * 4);
      e.waddr = inst[11:7];
      e.wdata = res;
      // x0 never written
      e.wen   = known && (inst[11:7] != 5'd0);
      if (e.wen) regs[inst[11:7]] = res;
    end
    return e;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("** Error: %s got %h expected %h (test %0d, commit %0d)",
             sig, got, want, test_num, commit_cnt);
    n_errors++;
  endtask

  //--------------------
  // Commit checker
  //--------------------
  // Trace sampled mid-cycle
  always @(negedge clk) begin
    if (checking && trace_val) begin
      exp_c = ref_commit(commit_cnt);
      n_checks++;
      if (trace_pc !== exp_c.pc) report_mismatch("trace_pc", trace_pc, exp_c.pc);
      if (trace_waddr !== exp_c.waddr) report_mismatch("trace_waddr", 32'(trace_waddr),
                                                       32'(exp_c.waddr));
      if (trace_wen !== exp_c.wen) report_mismatch("trace_wen", 32'(trace_wen), 32'(exp_c.wen));
      // Data only matters for a register write
      if (exp_c.wen && trace_wdata !== exp_c.wdata) report_mismatch("trace_wdata",
                                                                    trace_wdata, exp_c.wdata);
      commit_cnt++;
    end
  end

  //--------------------
  // Test sequencing
  //--------------------
  // Hold reset and clear memory to nops
  task automatic begin_test();
    @(negedge clk);
    rst_n = 1'b0;
    test_num++;
    commit_cnt = 0;
    for (int i = 0; i < mem_words; i++) imem[i] = nop_inst;
  endtask

  task automatic run_program(input string name, input int len);
    int err0;
    err0 = n_errors;
    // Trace stays quiet while reset is held
    repeat (3) begin
      @(negedge clk);
      if (trace_val !== 1'b0) report_mismatch("trace_val", 32'(trace_val), 32'h0);
    end
    rst_n    = 1'b1;
    checking = 1'b1;
    // Nothing can commit this early
    repeat (2) begin
      @(negedge clk);
      if (trace_val !== 1'b0) report_mismatch("trace_val", 32'(trace_val), 32'h0);
    end
    while (commit_cnt < len) @(posedge clk);
    checking = 1'b0;
    if (n_errors == err0) begin
      n_passed++;
      $display("test %0d %s: %0d commits checked, passed", test_num, name, commit_cnt);
    end else begin
      n_failed++;
      $display("test %0d %s: %0d errors, failed", test_num, name, n_errors - err0);
    end
  endtask

  task automatic load_random_program(input int len);
    logic [31:0] sel;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    for (int i = 0; i < len; i++) begin
      take_bits(2, sel);
      take_bits(3, rd);
      take_bits(3, rs1);
      take_bits(3, rs2);
      take_bits(12, imm);
      // Small register window keeps dependencies dense
      case (sel[1:0])
        2'd0:    imem[i] = enc_add(rd[4:0], rs1[4:0], rs2[4:0]);
        2'd1:    imem[i] = enc_mul(rd[4:0], rs1[4:0], rs2[4:0]);
        default: imem[i] = enc_addi(rd[4:0], rs1[4:0], imm[11:0]);
      endcase
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    checking   = 1'b0;
    lfsr_state = 32'h6533bb4a;
    commit_cnt = 0;
    test_num   = 0;
    n_checks   = 0;
    n_errors   = 0;
    n_passed   = 0;
    n_failed   = 0;
    for (int i = 0; i < mem_words; i++) imem[i] = nop_inst;

    begin_test();
    imem[0] = enc_addi(5'd1, 5'd0, 12'd1);
    imem[1] = enc_addi(5'd2, 5'd0, 12'd2);
    imem[2] = enc_add(5'd3, 5'd1, 5'd2);
    run_program("reset and first commit", 3);

    // Dependent chain with negative immediates
    begin_test();
    imem[0] = enc_addi(5'd1, 5'd0, -12'd5);
    imem[1] = enc_addi(5'd2, 5'd1, -12'd100);
    imem[2] = enc_add(5'd3, 5'd1, 5'd2);
    imem[3] = enc_addi(5'd3, 5'd3, 12'h800);
    imem[4] = enc_add(5'd4, 5'd3, 5'd3);
    imem[5] = enc_addi(5'd1, 5'd4, 12'd7);
    imem[6] = enc_add(5'd5, 5'd1, 5'd4);
    imem[7] = enc_addi(5'd5, 5'd5, -12'd1);
    run_program("dependent add chain", 8);

    // Adds overtake the mul and then consume it
    begin_test();
    imem[0] = enc_addi(5'd1, 5'd0, 12'd123);
    imem[1] = enc_addi(5'd2, 5'd0, -12'd7);
    imem[2] = enc_mul(5'd3, 5'd1, 5'd2);
    imem[3] = enc_addi(5'd4, 5'd0, 12'd1);
    imem[4] = enc_addi(5'd5, 5'd0, 12'd2);
    imem[5] = enc_add(5'd6, 5'd4, 5'd5);
    imem[6] = enc_add(5'd7, 5'd5, 5'd5);
    imem[7] = enc_add(5'd8, 5'd3, 5'd6);
    imem[8] = enc_mul(5'd9, 5'd8, 5'd8);
    imem[9] = enc_add(5'd10, 5'd9, 5'd1);
    run_program("mul completes last", 10);

    // Far more renames than physical registers
    begin_test();
    for (int i = 0; i < recycle_len; i++) begin
      case (i % 3)
        0:       imem[i] = enc_addi(5'd1, 5'd1, 12'(i * 5 - 60));
        1:       imem[i] = enc_add(5'd2, 5'd2, 5'd1);
        default: imem[i] = enc_mul(5'd3, 5'd2, 5'd1);
      endcase
    end
    run_program("free list recycling", recycle_len);

    // Writes to x0 are dropped and x0 reads zero
    begin_test();
    imem[0] = enc_addi(5'd1, 5'd0, 12'd9);
    imem[1] = enc_addi(5'd0, 5'd1, 12'd5);
    imem[2] = enc_add(5'd0, 5'd1, 5'd1);
    imem[3] = enc_mul(5'd0, 5'd1, 5'd1);
    imem[4] = enc_add(5'd2, 5'd0, 5'd1);
    imem[5] = enc_addi(5'd3, 5'd0, -12'd1);
    imem[6] = enc_mul(5'd4, 5'd0, 5'd3);
    run_program("x0 destination", 7);

    begin_test();
    load_random_program(rand_len);
    run_program("random program", rand_len);

    $display("tests: %0d passed, %0d failed, %0d commit checks, %0d errors",
             n_passed, n_failed, n_checks, n_errors);
    if (n_errors == 0 && n_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog of 40 cycles per instruction
  initial begin
    #(total_insts * 40 * clk_period);
    $display("watchdog: core stopped committing, run ended after %0d cycles",
             total_insts * 40);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/blimp_tb_asserts.sv ====
//--------------------
// Bound checks on the core ports:
// trace_val known, commit PC step, fetch alignment
//--------------------
`timescale 1ns/1ps
`default_nettype none

module blimp_tb_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] inst_mem_addr,
  input logic        trace_val,
  input logic [31:0] trace_pc
);

  // PC of the most recent commit
  logic [31:0] last_pc_q;
  logic        seen_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_pc_q <= 32'h0;
      seen_q    <= 1'b0;
    end else if (trace_val) begin
      last_pc_q <= trace_pc;
      seen_q    <= 1'b1;
    end
  end

  //--------------------
  // Properties
  //--------------------
  // Checked mid-cycle, trace and address are settled
  trace_val_known: assert property (@(negedge clk) disable iff (!rst_n)
    !$isunknown(trace_val))
    else $error("trace_val is unknown after reset");

  // Program order, no gaps between commits
  trace_pc_step: assert property (@(negedge clk) disable iff (!rst_n)
    (trace_val && seen_q) |-> (trace_pc == last_pc_q + 32'd4))
    else $error("trace_pc %h does not follow %h by 4", trace_pc, last_pc_q);

  fetch_aligned: assert property (@(negedge clk) disable iff (!rst_n)
    inst_mem_addr[1:0] == 2'b00)
    else $error("inst_mem_addr %h is not word aligned", inst_mem_addr);

endmodule

`default_nettype wire
